// ==== fpu_frontend.f ====
hw/fpu_pkg.sv
hw/fp_decoder.sv
hw/fp_operand_read.sv
hw/fp_issue_stage.sv
hw/fp_csr_axil.sv
hw/fpu_frontend.sv
tb/tb_fpu_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the fpu_frontend testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_fpu_frontend -f fpu_frontend.f -o tb_fpu_frontend
if [ $? -ne 0 ]; then
  echo "Compilation failed."
  exit 1
fi

./obj_dir/tb_fpu_frontend > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "Simulation FAILED."
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status."
  exit 1
fi
echo "Simulation PASSED."
exit 0

// ==== tb/tb_fpu_frontend.sv ====
`timescale 1ns/10ps

module tb_fpu_frontend;
  import fpu_pkg::*;

  localparam int MAX_CYCLES = 2000;

  logic         clock;
  logic         reset;
  logic         instr_valid_i;
  logic [31:0]  instr_i;
  logic         instr_ready_o;
  fp_write_t    ex_fwd_i;
  fp_write_t    mem_wb_i;
  fp_exc_t      exc_i;
  axil_req_t    csr_req_i;
  axil_rsp_t    csr_rsp_o;
  logic         issue_valid_o;
  fp_issue_t    issue_o;
  logic         issue_ready_i;

  logic [FLEN-1:0] reg_model [NUM_FP_REGS];
  logic [31:0]     lcg_state = 32'd59544;
  int              cycle_count = 0;

  fpu_frontend i_fpu_frontend (
    .clock         (clock),
    .reset         (reset),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .ex_fwd_i      (ex_fwd_i),
    .mem_wb_i      (mem_wb_i),
    .exc_i         (exc_i),
    .csr_req_i     (csr_req_i),
    .csr_rsp_o     (csr_rsp_o),
    .issue_valid_o (issue_valid_o),
    .issue_o       (issue_o),
    .issue_ready_i (issue_ready_i)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
      stop_on_failure();
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // Instruction encoders, double precision format in every case.
  function automatic logic [31:0] enc_r(input logic [4:0] f5, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f5, 2'b01, rs2, rs1, f3, rd, 7'b1010011};
  endfunction

  function automatic logic [31:0] enc_r4(input logic [6:0] opc, input logic [4:0] rs3,
                                         input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [2:0] rm, input logic [4:0] rd);
    return {rs3, 2'b01, rs2, rs1, rm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_load(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0000111};
  endfunction

  function automatic logic [31:0] enc_store(input logic [11:0] imm, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100111};
  endfunction

  // Enable order is wren, rden1, fwren, frden1, frden2, frden3, fpuc, fpuf.
  function automatic fp_decode_t expect_decode(input logic [31:0] instr, input logic legal,
                                               input fp_op_e op, input lsu_op_e lsu,
                                               input logic [31:0] imm, input logic [7:0] en);
    fp_decode_t d;
    d.legal   = legal;
    d.op      = op;
    d.lsu_op  = lsu;
    d.imm     = imm;
    {d.wren, d.rden1, d.fwren, d.frden1, d.frden2, d.frden3, d.fpuc, d.fpuf} = en;
    d.fmt     = instr[26:25];
    d.rm      = instr[14:12];
    d.fcvt_op = instr[21:20];
    d.rd      = instr[11:7];
    d.rs1     = instr[19:15];
    d.rs2     = instr[24:20];
    d.rs3     = instr[31:27];
    return d;
  endfunction

  function automatic fp_operands_t make_ops(input logic [63:0] d1, input logic [63:0] d2,
                                            input logic [63:0] d3);
    fp_operands_t ops;
    ops.data1 = d1;
    ops.data2 = d2;
    ops.data3 = d3;
    return ops;
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_decode(input string name, input fp_decode_t got, input fp_decode_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_operands(input string name, input fp_operands_t got,
                                input fp_operands_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_rm(input string name, input logic [2:0] got, input logic [2:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_csr(input string name, input logic [31:0] got_data,
                           input logic [1:0] got_resp, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
    if (got_data !== exp_data || got_resp !== exp_resp) begin
      $display("mismatch %s: got data %h resp %h, expected data %h resp %h",
               name, got_data, got_resp, exp_data, exp_resp);
      stop_on_failure();
    end
  endtask

  // Returns just after the acceptance edge, with the packet on issue_o.
  task automatic send_instr(input logic [31:0] instr);
    instr_valid_i = 1'b1;
    instr_i       = instr;
    @(negedge clock);
    while (!instr_ready_o) begin
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    instr_valid_i = 1'b0;
    check_flag("issue_valid_o", issue_valid_o, 1'b1);
  endtask

  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    csr_req_i.awvalid = 1'b1;
    csr_req_i.awaddr  = addr;
    csr_req_i.wvalid  = 1'b1;
    csr_req_i.wdata   = data;
    csr_req_i.wstrb   = 4'hf;
    @(negedge clock);
    while (!(csr_rsp_o.awready && csr_rsp_o.wready)) begin
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    csr_req_i.awvalid = 1'b0;
    csr_req_i.wvalid  = 1'b0;
    while (!csr_rsp_o.bvalid) begin
      @(posedge clock);
      #2;
    end
    resp = csr_rsp_o.bresp;
    csr_req_i.bready = 1'b1;
    @(posedge clock);
    #2;
    csr_req_i.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    csr_req_i.arvalid = 1'b1;
    csr_req_i.araddr  = addr;
    @(negedge clock);
    while (!csr_rsp_o.arready) begin
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    csr_req_i.arvalid = 1'b0;
    while (!csr_rsp_o.rvalid) begin
      @(posedge clock);
      #2;
    end
    data = csr_rsp_o.rdata;
    resp = csr_rsp_o.rresp;
    csr_req_i.rready = 1'b1;
    @(posedge clock);
    #2;
    csr_req_i.rready = 1'b0;
  endtask

  task automatic decode_case(input logic [31:0] instr, input logic legal, input fp_op_e op,
                             input lsu_op_e lsu, input logic [31:0] imm, input logic [7:0] en);
    send_instr(instr);
    check_decode("issue_o.decode", issue_o.decode, expect_decode(instr, legal, op, lsu, imm, en));
  endtask

  task automatic test_register_read();
    logic [31:0] rnd;
    logic [4:0]  a;
    logic [4:0]  b;
    logic [4:0]  c;
    for (int i = 0; i < NUM_FP_REGS; i++) begin
      mem_wb_i.wren  = 1'b1;
      mem_wb_i.waddr = 5'(i);
      mem_wb_i.wdata = rand64();
      reg_model[i]   = mem_wb_i.wdata;
      @(posedge clock);
      #2;
    end
    mem_wb_i = '0;
    for (int n = 0; n < 8; n++) begin
      rnd = lcg_next();
      a = rnd[4:0];
      b = rnd[12:8];
      c = rnd[20:16];
      send_instr(enc_r4(opc_fnmadd, c, b, a, 3'b000, 5'd1));
      check_operands("operands fnmadd", issue_o.operands,
                     make_ops(reg_model[a], reg_model[b], reg_model[c]));
    end
    // Unused sources come out as zero.
    send_instr(enc_r(5'b00000, 5'd12, 5'd13, 3'b000, 5'd1));
    check_operands("operands fadd", issue_o.operands, make_ops(reg_model[13], reg_model[12], '0));
    send_instr(enc_r(5'b01011, 5'd0, 5'd14, 3'b000, 5'd1));
    check_operands("operands fsqrt", issue_o.operands, make_ops(reg_model[14], '0, '0));
    send_instr(enc_r(5'b11110, 5'd0, 5'd15, 3'b000, 5'd1));
    check_operands("operands fmv_i2f", issue_o.operands, make_ops(reg_model[15], '0, '0));
    send_instr(enc_load(12'h3c4, 5'd16, 3'b011, 5'd1));
    check_operands("operands fld", issue_o.operands, make_ops(reg_model[16], '0, '0));
    send_instr(enc_r(5'b10100, 5'd17, 5'd18, 3'b010, 5'd1));
    check_operands("operands fcmp", issue_o.operands, make_ops(reg_model[18], reg_model[17], '0));
  endtask

  task automatic test_decode();
    decode_case(enc_load(12'hff8, 5'd2, 3'b010, 5'd3), 1'b1, op_fload, lsu_lw,
                32'hffff_fff8, 8'b0110_0000);
    decode_case(enc_load(12'h07f, 5'd4, 3'b011, 5'd9), 1'b1, op_fload, lsu_ld,
                32'h0000_007f, 8'b0110_0000);
    decode_case(enc_store(12'h804, 5'd6, 5'd1, 3'b010), 1'b1, op_fstore, lsu_sw,
                32'hffff_f804, 8'b0100_1000);
    decode_case(enc_store(12'h010, 5'd7, 5'd8, 3'b011), 1'b1, op_fstore, lsu_sd,
                32'h0000_0010, 8'b0100_1000);
    decode_case(enc_r(5'b00000, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, op_fadd, lsu_none, '0, 8'h3b);
    decode_case(enc_r(5'b00001, 5'd3, 5'd2, 3'b001, 5'd5), 1'b1, op_fsub, lsu_none, '0, 8'h3b);
    decode_case(enc_r(5'b00010, 5'd4, 5'd3, 3'b010, 5'd6), 1'b1, op_fmul, lsu_none, '0, 8'h3b);
    decode_case(enc_r(5'b00011, 5'd5, 5'd4, 3'b011, 5'd7), 1'b1, op_fdiv, lsu_none, '0, 8'h3b);
    decode_case(enc_r(5'b01011, 5'd0, 5'd5, 3'b100, 5'd8), 1'b1, op_fsqrt, lsu_none, '0, 8'h33);
    decode_case(enc_r(5'b00100, 5'd6, 5'd7, 3'b001, 5'd9), 1'b1, op_fsgnj, lsu_none, '0, 8'h38);
    decode_case(enc_r(5'b00101, 5'd8, 5'd9, 3'b000, 5'd10), 1'b1, op_fminmax, lsu_none, '0,
                8'h39);
    decode_case(enc_r(5'b01000, 5'd1, 5'd10, 3'b000, 5'd11), 1'b1, op_fcvt_f2f, lsu_none, '0,
                8'h31);
    decode_case(enc_r(5'b10100, 5'd11, 5'd12, 3'b010, 5'd12), 1'b1, op_fcmp, lsu_none, '0, 8'h99);
    decode_case(enc_r(5'b11000, 5'd0, 5'd13, 3'b001, 5'd13), 1'b1, op_fcvt_f2i, lsu_none, '0,
                8'h91);
    decode_case(enc_r(5'b11010, 5'd2, 5'd14, 3'b000, 5'd14), 1'b1, op_fcvt_i2f, lsu_none, '0,
                8'h61);
    decode_case(enc_r(5'b11100, 5'd0, 5'd15, 3'b000, 5'd15), 1'b1, op_fmv_f2i, lsu_none, '0,
                8'h90);
    decode_case(enc_r(5'b11100, 5'd0, 5'd16, 3'b001, 5'd16), 1'b1, op_fclass, lsu_none, '0,
                8'h90);
    decode_case(enc_r(5'b11110, 5'd0, 5'd17, 3'b000, 5'd17), 1'b1, op_fmv_i2f, lsu_none, '0,
                8'h60);
    decode_case(enc_r4(opc_fmadd, 5'd3, 5'd2, 5'd1, 3'b000, 5'd4), 1'b1, op_fmadd, lsu_none,
                '0, 8'h3f);
    decode_case(enc_r4(opc_fmsub, 5'd6, 5'd5, 5'd4, 3'b001, 5'd7), 1'b1, op_fmsub, lsu_none,
                '0, 8'h3f);
    decode_case(enc_r4(opc_fnmsub, 5'd9, 5'd8, 5'd7, 3'b010, 5'd1), 1'b1, op_fnmsub, lsu_none,
                '0, 8'h3f);
    decode_case(enc_r4(opc_fnmadd, 5'd12, 5'd11, 5'd10, 3'b111, 5'd2), 1'b1, op_fnmadd,
                lsu_none, '0, 8'h3f);
    decode_case(32'h0020_81b3, 1'b0, op_none, lsu_none, '0, 8'h00);  // Integer add.
  endtask

  task automatic test_forwarding();
    logic [31:0] instr;
    logic [63:0] ex_val;
    logic [63:0] mem_val;
    instr = enc_r4(opc_fmadd, 5'd7, 5'd6, 5'd5, 3'b000, 5'd1);
    for (int k = 0; k < 4; k++) begin
      ex_val  = rand64();
      mem_val = rand64();
      ex_fwd_i.wren   = (k != 2);
      ex_fwd_i.waddr  = (k == 1) ? 5'd6 : ((k == 3) ? 5'd7 : 5'd5);
      ex_fwd_i.wdata  = ex_val;
      mem_wb_i.wren   = 1'b1;
      mem_wb_i.waddr  = (k == 1) ? 5'd7 : ((k == 3) ? 5'd20 : 5'd5);
      mem_wb_i.wdata  = mem_val;
      send_instr(instr);
      ex_fwd_i = '0;
      mem_wb_i = '0;
      case (k)
        0: check_operands("operands ex over mem", issue_o.operands,
                          make_ops(ex_val, reg_model[6], reg_model[7]));
        1: check_operands("operands ex and mem split", issue_o.operands,
                          make_ops(reg_model[5], ex_val, mem_val));
        2: check_operands("operands mem with ex idle", issue_o.operands,
                          make_ops(mem_val, reg_model[6], reg_model[7]));
        default: check_operands("operands ex on rs3", issue_o.operands,
                                make_ops(reg_model[5], reg_model[6], ex_val));
      endcase
      if (k == 1) begin
        reg_model[7] = mem_val;
      end else if (k == 3) begin
        reg_model[20] = mem_val;
      end else begin
        reg_model[5] = mem_val;  // The write-back port also fills the register file.
      end
    end
  endtask

  task automatic test_csr_access();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_write(csr_frm, 32'd3, resp);
    check_csr("bresp frm", 32'd0, resp, 32'd0, AXI_RESP_OKAY);
    axil_write(csr_fflags, 32'h15, resp);
    check_csr("bresp fflags", 32'd0, resp, 32'd0, AXI_RESP_OKAY);
    axil_read(csr_frm, data, resp);
    check_csr("read frm", data, resp, 32'd3, AXI_RESP_OKAY);
    axil_read(csr_fflags, data, resp);
    check_csr("read fflags", data, resp, 32'h15, AXI_RESP_OKAY);
    axil_read(csr_fcsr, data, resp);
    check_csr("read fcsr", data, resp, 32'h75, AXI_RESP_OKAY);
    axil_write(csr_fcsr, 32'habcd_00c9, resp);
    check_csr("bresp fcsr", 32'd0, resp, 32'd0, AXI_RESP_OKAY);
    axil_read(csr_frm, data, resp);
    check_csr("read frm after fcsr", data, resp, 32'd6, AXI_RESP_OKAY);
    axil_read(csr_fflags, data, resp);
    check_csr("read fflags after fcsr", data, resp, 32'h09, AXI_RESP_OKAY);
    axil_read(csr_fcsr, data, resp);
    check_csr("read fcsr after fcsr", data, resp, 32'hc9, AXI_RESP_OKAY);
    axil_write(12'h004, 32'h7, resp);
    check_csr("bresp unmapped", 32'd0, resp, 32'd0, AXI_RESP_SLVERR);
    axil_read(12'h004, data, resp);
    check_csr("read unmapped", data, resp, 32'd0, AXI_RESP_SLVERR);
    axil_read(csr_frm, data, resp);
    check_csr("read frm after unmapped write", data, resp, 32'd6, AXI_RESP_OKAY);
  endtask

  task automatic test_rounding_and_flags();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_write(csr_frm, 32'd2, resp);
    check_csr("bresp frm", 32'd0, resp, 32'd0, AXI_RESP_OKAY);
    send_instr(enc_r(5'b00000, 5'd1, 5'd2, 3'b111, 5'd3));
    check_rm("issue_o.rm_eff dynamic", issue_o.rm_eff, 3'd2);
    send_instr(enc_r(5'b00000, 5'd1, 5'd2, 3'b001, 5'd3));
    check_rm("issue_o.rm_eff static", issue_o.rm_eff, 3'd1);
    axil_write(csr_frm, 32'd4, resp);
    send_instr(enc_r4(opc_fmadd, 5'd3, 5'd2, 5'd1, 3'b111, 5'd4));
    check_rm("issue_o.rm_eff dynamic fmadd", issue_o.rm_eff, 3'd4);
    exc_i.valid = 1'b1;
    exc_i.flags = 5'h1a;
    @(posedge clock);
    #2;
    exc_i = '0;
    axil_read(csr_fflags, data, resp);
    check_csr("read fflags after exception", data, resp, 32'h1a, AXI_RESP_OKAY);
  endtask

  task automatic test_back_pressure();
    logic [31:0] instr_a;
    logic [31:0] instr_b;
    fp_decode_t  exp_a;
    fp_decode_t  exp_b;
    instr_a = enc_r(5'b00100, 5'd9, 5'd8, 3'b000, 5'd1);
    instr_b = enc_r(5'b00010, 5'd11, 5'd10, 3'b001, 5'd2);
    exp_a   = expect_decode(instr_a, 1'b1, op_fsgnj, lsu_none, '0, 8'h38);
    exp_b   = expect_decode(instr_b, 1'b1, op_fmul, lsu_none, '0, 8'h3b);
    issue_ready_i = 1'b0;
    send_instr(instr_a);
    instr_valid_i = 1'b1;
    instr_i       = instr_b;
    repeat (3) begin
      @(negedge clock);
      check_flag("instr_ready_o", instr_ready_o, 1'b0);
      @(posedge clock);
      #2;
      check_flag("issue_valid_o", issue_valid_o, 1'b1);
      check_decode("issue_o.decode held", issue_o.decode, exp_a);
      check_operands("issue_o.operands held", issue_o.operands,
                     make_ops(reg_model[8], reg_model[9], '0));
      check_rm("issue_o.rm_eff held", issue_o.rm_eff, 3'd0);
    end
    issue_ready_i = 1'b1;
    send_instr(instr_b);
    check_decode("issue_o.decode after release", issue_o.decode, exp_b);
    check_operands("issue_o.operands after release", issue_o.operands,
                   make_ops(reg_model[10], reg_model[11], '0));
  endtask

  initial begin
    reset         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    ex_fwd_i      = '0;
    mem_wb_i      = '0;
    exc_i         = '0;
    csr_req_i     = '0;
    issue_ready_i = 1'b1;
    repeat (2) @(posedge clock);
    #2;
    reset = 1'b1;
    test_register_read();
    test_decode();
    test_forwarding();
    test_csr_access();
    test_rounding_and_flags();
    test_back_pressure();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== hw/fpu_frontend.sv ====
`timescale 1ns/10ps

module fpu_frontend (
  input  logic               clock,
  input  logic               reset,
  input  logic               instr_valid_i,
  input  logic [31:0]        instr_i,
  output logic               instr_ready_o,
  input  fpu_pkg::fp_write_t ex_fwd_i,
  input  fpu_pkg::fp_write_t mem_wb_i,
  input  fpu_pkg::fp_exc_t   exc_i,
  input  fpu_pkg::axil_req_t csr_req_i,
  output fpu_pkg::axil_rsp_t csr_rsp_o,
  output logic               issue_valid_o,
  output fpu_pkg::fp_issue_t issue_o,
  input  logic               issue_ready_i
);
  import fpu_pkg::*;

  fp_decode_t   decode;
  fp_operands_t operands;
  logic [2:0]   frm;

  fp_decoder i_fp_decoder (
    .instr_i  (instr_i),
    .decode_o (decode)
  );

  fp_operand_read i_fp_operand_read (
    .clock      (clock),
    .instr_i    (instr_i),
    .ex_fwd_i   (ex_fwd_i),
    .mem_wb_i   (mem_wb_i),
    .operands_o (operands)
  );

  fp_issue_stage i_fp_issue_stage (
    .clock         (clock),
    .reset         (reset),
    .decode_i      (decode),
    .operands_i    (operands),
    .frm_i         (frm),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .issue_valid_o (issue_valid_o),
    .issue_o       (issue_o),
    .issue_ready_i (issue_ready_i)
  );

  fp_csr_axil i_fp_csr_axil (
    .clock     (clock),
    .reset     (reset),
    .csr_req_i (csr_req_i),
    .csr_rsp_o (csr_rsp_o),
    .exc_i     (exc_i),
    .frm_o     (frm)
  );

endmodule

// ==== hw/fp_csr_axil.sv ====
`timescale 1ns/10ps

module fp_csr_axil (
  input  logic               clock,
  input  logic               reset,
  input  fpu_pkg::axil_req_t csr_req_i,
  output fpu_pkg::axil_rsp_t csr_rsp_o,
  input  fpu_pkg::fp_exc_t   exc_i,
  output logic [2:0]         frm_o
);
  import fpu_pkg::*;

  logic [2:0]      frm_q;
  logic [4:0]      fflags_q;
  logic            bvalid_q;
  logic            rvalid_q;
  logic [1:0]      bresp_q;
  logic [1:0]      rresp_q;
  logic [XLEN-1:0] rdata_q;
  logic [XLEN-1:0] rd_value;
  logic            wr_accept;
  logic            rd_accept;

  function automatic logic csr_mapped(input logic [CSR_ADDR_W-1:0] addr);
    return addr inside {csr_fflags, csr_frm, csr_fcsr};
  endfunction

  // Address and data must arrive together, one transaction in flight per channel.
  assign wr_accept = csr_req_i.awvalid && csr_req_i.wvalid && !bvalid_q;
  assign rd_accept = csr_req_i.arvalid && !rvalid_q;

  always_comb begin
    case (csr_req_i.araddr)
      csr_fflags: rd_value = {{(XLEN-5){1'b0}}, fflags_q};
      csr_frm:    rd_value = {{(XLEN-3){1'b0}}, frm_q};
      csr_fcsr:   rd_value = {{(XLEN-8){1'b0}}, frm_q, fflags_q};
      default:    rd_value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      frm_q    <= '0;
      fflags_q <= '0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_accept && csr_req_i.wstrb[0]) begin
        case (csr_req_i.awaddr)
          csr_fflags: fflags_q <= csr_req_i.wdata[4:0];
          csr_frm:    frm_q <= csr_req_i.wdata[2:0];
          csr_fcsr: begin
            fflags_q <= csr_req_i.wdata[4:0];
            frm_q    <= csr_req_i.wdata[7:5];
          end
          default: ;
        endcase
      end
      if (exc_i.valid) begin
        fflags_q <= exc_i.flags;  // Execute side beats the bus.
      end
      if (wr_accept) begin
        bvalid_q <= 1'b1;
      end else if (csr_req_i.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (csr_req_i.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      bresp_q <= csr_mapped(csr_req_i.awaddr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
    if (rd_accept) begin
      rresp_q <= csr_mapped(csr_req_i.araddr) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      rdata_q <= rd_value;
    end
  end

  assign csr_rsp_o.awready = wr_accept;
  assign csr_rsp_o.wready  = wr_accept;
  assign csr_rsp_o.bvalid  = bvalid_q;
  assign csr_rsp_o.bresp   = bresp_q;
  assign csr_rsp_o.arready = rd_accept;
  assign csr_rsp_o.rvalid  = rvalid_q;
  assign csr_rsp_o.rdata   = rdata_q;
  assign csr_rsp_o.rresp   = rresp_q;
  assign frm_o             = frm_q;

  a_bvalid_hold: assert property (@(posedge clock) disable iff (!reset)
    bvalid_q && !csr_req_i.bready |=> bvalid_q && $stable(bresp_q))
    else $error("Write response dropped before bready.");

endmodule

// ==== hw/fp_issue_stage.sv ====
`timescale 1ns/10ps

module fp_issue_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  fpu_pkg::fp_decode_t   decode_i,
  input  fpu_pkg::fp_operands_t operands_i,
  input  logic [2:0]            frm_i,
  input  logic                  instr_valid_i,
  output logic                  instr_ready_o,
  output logic                  issue_valid_o,
  output fpu_pkg::fp_issue_t    issue_o,
  input  logic                  issue_ready_i
);
  import fpu_pkg::*;

  fp_issue_t packet;
  fp_issue_t issue_q;
  logic      issue_valid_q;

  assign instr_ready_o = !issue_valid_q || issue_ready_i;  // Empty or draining this cycle.

  always_comb begin
    packet.decode = decode_i;
    // Integer sources on data1 keep the slot as well.
    packet.operands.data1 = (decode_i.frden1 || decode_i.rden1) ? operands_i.data1 : '0;
    packet.operands.data2 = decode_i.frden2 ? operands_i.data2 : '0;
    packet.operands.data3 = decode_i.frden3 ? operands_i.data3 : '0;
    packet.rm_eff = (decode_i.rm == RM_DYN) ? frm_i : decode_i.rm;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue_valid_q <= 1'b0;
    end else if (instr_ready_o) begin
      issue_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (instr_valid_i && instr_ready_o) begin
      issue_q <= packet;
    end
  end

  assign issue_valid_o = issue_valid_q;
  assign issue_o       = issue_q;

  a_issue_hold: assert property (@(posedge clock) disable iff (!reset)
    issue_valid_q && !issue_ready_i |=> issue_valid_q && $stable(issue_q))
    else $error("Issue packet changed under back-pressure.");

endmodule

// ==== hw/fp_operand_read.sv ====
`timescale 1ns/10ps

module fp_operand_read (
  input  logic                  clock,
  input  logic [31:0]           instr_i,
  input  fpu_pkg::fp_write_t    ex_fwd_i,
  input  fpu_pkg::fp_write_t    mem_wb_i,
  output fpu_pkg::fp_operands_t operands_o
);
  import fpu_pkg::*;

  logic [FLEN-1:0]       regs [NUM_FP_REGS];
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rs3;

  // The execute stage holds the youngest result, so it wins over write-back.
  function automatic logic [FLEN-1:0] forward(
    input logic [REG_ADDR_W-1:0] raddr,
    input logic [FLEN-1:0]       rdata,
    input fp_write_t             ex,
    input fp_write_t             mem
  );
    logic [FLEN-1:0] res;
    if (ex.wren && (ex.waddr == raddr)) begin
      res = ex.wdata;
    end else if (mem.wren && (mem.waddr == raddr)) begin
      res = mem.wdata;
    end else begin
      res = rdata;
    end
    return res;
  endfunction

  always_ff @(posedge clock) begin
    if (mem_wb_i.wren) begin
      regs[mem_wb_i.waddr] <= mem_wb_i.wdata;
    end
  end

  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];
  assign rs3 = instr_i[31:27];

  assign operands_o.data1 = forward(rs1, regs[rs1], ex_fwd_i, mem_wb_i);
  assign operands_o.data2 = forward(rs2, regs[rs2], ex_fwd_i, mem_wb_i);
  assign operands_o.data3 = forward(rs3, regs[rs3], ex_fwd_i, mem_wb_i);

  a_write_ports_known: assert property (@(posedge clock)
    !((ex_fwd_i.wren && $isunknown(ex_fwd_i)) || (mem_wb_i.wren && $isunknown(mem_wb_i))))
    else $error("Forwarding or write-back port carries unknowns while enabled.");

endmodule

// ==== hw/fp_decoder.sv ====
`timescale 1ns/10ps

module fp_decoder (
  input  logic [31:0]         instr_i,
  output fpu_pkg::fp_decode_t decode_o
);
  import fpu_pkg::*;

  localparam logic [2:0] F3_WORD   = 3'b010;
  localparam logic [2:0] F3_DOUBLE = 3'b011;

  localparam logic [4:0] F5_FADD     = 5'b00000;
  localparam logic [4:0] F5_FSUB     = 5'b00001;
  localparam logic [4:0] F5_FMUL     = 5'b00010;
  localparam logic [4:0] F5_FDIV     = 5'b00011;
  localparam logic [4:0] F5_FSGNJ    = 5'b00100;
  localparam logic [4:0] F5_FMINMAX  = 5'b00101;
  localparam logic [4:0] F5_FCVT_F2F = 5'b01000;
  localparam logic [4:0] F5_FSQRT    = 5'b01011;
  localparam logic [4:0] F5_FCMP     = 5'b10100;
  localparam logic [4:0] F5_FCVT_F2I = 5'b11000;
  localparam logic [4:0] F5_FCVT_I2F = 5'b11010;
  localparam logic [4:0] F5_FMV_F2I  = 5'b11100;
  localparam logic [4:0] F5_FMV_I2F  = 5'b11110;

  opcode_e         opcode;
  logic [4:0]      funct5;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  fp_decode_t      dec;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct5 = instr_i[31:27];
  assign funct3 = instr_i[14:12];
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  always_comb begin
    dec         = '0;
    dec.legal   = 1'b1;
    dec.fmt     = instr_i[26:25];
    dec.rm      = funct3;
    dec.fcvt_op = instr_i[21:20];
    dec.rd      = instr_i[11:7];
    dec.rs1     = instr_i[19:15];
    dec.rs2     = instr_i[24:20];
    dec.rs3     = instr_i[31:27];

    // The operation comes first, the enables then follow from it.
    case (opcode)
      opc_fload: begin
        dec.op  = op_fload;
        dec.imm = imm_i;
        case (funct3)
          F3_WORD:   dec.lsu_op = lsu_lw;
          F3_DOUBLE: dec.lsu_op = lsu_ld;
          default:   dec.legal = 1'b0;
        endcase
      end
      opc_fstore: begin
        dec.op  = op_fstore;
        dec.imm = imm_s;
        case (funct3)
          F3_WORD:   dec.lsu_op = lsu_sw;
          F3_DOUBLE: dec.lsu_op = lsu_sd;
          default:   dec.legal = 1'b0;
        endcase
      end
      opc_fp: begin
        case (funct5)
          F5_FADD:     dec.op = op_fadd;
          F5_FSUB:     dec.op = op_fsub;
          F5_FMUL:     dec.op = op_fmul;
          F5_FDIV:     dec.op = op_fdiv;
          F5_FSQRT:    dec.op = op_fsqrt;
          F5_FSGNJ:    dec.op = op_fsgnj;
          F5_FMINMAX:  dec.op = op_fminmax;
          F5_FCMP:     dec.op = op_fcmp;
          F5_FMV_I2F:  dec.op = op_fmv_i2f;
          F5_FCVT_F2F: dec.op = op_fcvt_f2f;
          F5_FCVT_F2I: dec.op = op_fcvt_f2i;
          F5_FCVT_I2F: dec.op = op_fcvt_i2f;
          F5_FMV_F2I: begin
            case (funct3)
              3'd0:    dec.op = op_fmv_f2i;
              3'd1:    dec.op = op_fclass;
              default: dec.op = op_none;  // Stays legal but does nothing.
            endcase
          end
          default: dec.legal = 1'b0;
        endcase
      end
      opc_fmadd:  dec.op = op_fmadd;
      opc_fmsub:  dec.op = op_fmsub;
      opc_fnmsub: dec.op = op_fnmsub;
      opc_fnmadd: dec.op = op_fnmadd;
      default:    dec.legal = 1'b0;
    endcase

    if (!dec.legal) begin
      dec.op     = op_none;
      dec.lsu_op = lsu_none;
      dec.imm    = '0;
    end

    case (dec.op)
      op_fload:    {dec.rden1, dec.fwren} = 2'b11;
      op_fstore:   {dec.rden1, dec.frden2} = 2'b11;
      op_fadd, op_fsub, op_fmul, op_fdiv:
        {dec.fwren, dec.frden1, dec.frden2, dec.fpuc, dec.fpuf} = 5'b11111;
      op_fsqrt:    {dec.fwren, dec.frden1, dec.fpuc, dec.fpuf} = 4'b1111;
      op_fsgnj:    {dec.fwren, dec.frden1, dec.frden2} = 3'b111;
      op_fminmax:  {dec.fwren, dec.frden1, dec.frden2, dec.fpuf} = 4'b1111;
      op_fcmp:     {dec.wren, dec.frden1, dec.frden2, dec.fpuf} = 4'b1111;
      op_fmv_f2i, op_fclass:
        {dec.wren, dec.frden1} = 2'b11;
      op_fmv_i2f:  {dec.rden1, dec.fwren} = 2'b11;
      op_fcvt_f2f: {dec.fwren, dec.frden1, dec.fpuf} = 3'b111;
      op_fcvt_f2i: {dec.wren, dec.frden1, dec.fpuf} = 3'b111;
      op_fcvt_i2f: {dec.rden1, dec.fwren, dec.fpuf} = 3'b111;
      op_fmadd, op_fmsub, op_fnmsub, op_fnmadd:
        {dec.fwren, dec.frden1, dec.frden2, dec.frden3, dec.fpuc, dec.fpuf} = 6'b111111;
      default: ;
    endcase
  end

  assign decode_o = dec;

endmodule

// ==== hw/fpu_pkg.sv ====
package fpu_pkg;

  localparam int FLEN        = 64;
  localparam int XLEN        = 32;
  localparam int NUM_FP_REGS = 32;
  localparam int REG_ADDR_W  = 5;
  localparam int CSR_ADDR_W  = 12;  // AXI addresses carry the CSR number directly.

  localparam logic [2:0] RM_DYN = 3'd7;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  typedef enum logic [6:0] {
    opc_fload  = 7'b0000111,
    opc_fstore = 7'b0100111,
    opc_fp     = 7'b1010011,
    opc_fmadd  = 7'b1000011,
    opc_fmsub  = 7'b1000111,
    opc_fnmsub = 7'b1001011,
    opc_fnmadd = 7'b1001111
  } opcode_e;

  typedef enum logic [4:0] {
    op_none, op_fadd, op_fsub, op_fmul, op_fdiv, op_fsqrt, op_fsgnj,
    op_fminmax, op_fcmp, op_fmv_f2i, op_fclass, op_fmv_i2f, op_fcvt_f2f,
    op_fcvt_f2i, op_fcvt_i2f, op_fmadd, op_fmsub, op_fnmsub, op_fnmadd,
    op_fload, op_fstore
  } fp_op_e;

  typedef enum logic [2:0] {
    lsu_none, lsu_lw, lsu_ld, lsu_sw, lsu_sd
  } lsu_op_e;

  typedef enum logic [CSR_ADDR_W-1:0] {
    csr_fflags = 12'h001,
    csr_frm    = 12'h002,
    csr_fcsr   = 12'h003
  } csr_addr_e;

  typedef struct packed {
    logic                  legal;
    fp_op_e                op;
    lsu_op_e               lsu_op;
    logic [XLEN-1:0]       imm;
    logic                  wren;    // Writes the integer register file.
    logic                  rden1;   // Reads an integer source in rs1.
    logic                  fwren;
    logic                  frden1;
    logic                  frden2;
    logic                  frden3;
    logic                  fpuc;    // Long latency arithmetic.
    logic                  fpuf;    // May raise exception flags.
    logic [1:0]            fmt;
    logic [2:0]            rm;
    logic [1:0]            fcvt_op;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs3;
  } fp_decode_t;

  typedef struct packed {
    logic                  wren;
    logic [REG_ADDR_W-1:0] waddr;
    logic [FLEN-1:0]       wdata;
  } fp_write_t;

  typedef struct packed {
    logic [FLEN-1:0] data1;
    logic [FLEN-1:0] data2;
    logic [FLEN-1:0] data3;
  } fp_operands_t;

  typedef struct packed {
    fp_decode_t   decode;
    fp_operands_t operands;
    logic [2:0]   rm_eff;
  } fp_issue_t;

  typedef struct packed {
    logic                  awvalid;
    logic [CSR_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic [XLEN-1:0]       wdata;
    logic [XLEN/8-1:0]     wstrb;
    logic                  bready;
    logic                  arvalid;
    logic [CSR_ADDR_W-1:0] araddr;
    logic                  rready;
  } axil_req_t;

  typedef struct packed {
    logic            awready;
    logic            wready;
    logic            bvalid;
    logic [1:0]      bresp;
    logic            arready;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
    logic [1:0]      rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic       valid;
    logic [4:0] flags;
  } fp_exc_t;

endpackage
